// ==== dv/ball_checker.sv ====
`timescale 1ns/1ps

module ball_checker import ball_pkg::*; #(
	parameter int NAME_W = 192
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic              strobe,
	input  logic [NAME_W-1:0] test_name,
	input  ball_pos_t         exp_pos,
	input  logic [7:0]        exp_s1,
	input  logic [7:0]        exp_s2,
	input  ball_pos_t         ball_pos,
	input  logic              score_team1,
	input  logic              score_team2,
	output logic              done,
	output int                pass_count,
	output int                fail_count
);

	logic [7:0] cnt1;
	logic [7:0] cnt2;
	logic [7:0] tot1;
	logic [7:0] tot2;
	logic       ok;

	// totals include a pulse seen on this very edge
	assign tot1 = cnt1 + 8'(score_team1);
	assign tot2 = cnt2 + 8'(score_team2);

	always @(posedge clk) begin
		if (rst) begin
			cnt1 <= '0;
			cnt2 <= '0;
			done <= 1'b0;
			pass_count <= 0;
			fail_count <= 0;
		end else begin
			done <= 1'b0;
			if (start) begin
				cnt1 <= '0;
				cnt2 <= '0;
			end else begin
				cnt1 <= tot1;
				cnt2 <= tot2;
			end
			if (strobe) begin
				ok = 1'b1;
				if (ball_pos.x != exp_pos.x) begin
					$display("mismatch %0s x expected %0d actual %0d",
						test_name, exp_pos.x, ball_pos.x);
					ok = 1'b0;
				end
				if (ball_pos.y != exp_pos.y) begin
					$display("mismatch %0s y expected %0d actual %0d",
						test_name, exp_pos.y, ball_pos.y);
					ok = 1'b0;
				end
				if (tot1 != exp_s1) begin
					$display("mismatch %0s score_team1 pulses expected %0d actual %0d",
						test_name, exp_s1, tot1);
					ok = 1'b0;
				end
				if (tot2 != exp_s2) begin
					$display("mismatch %0s score_team2 pulses expected %0d actual %0d",
						test_name, exp_s2, tot2);
					ok = 1'b0;
				end
				if (ok) begin
					$display("test %0s ok", test_name);
					pass_count <= pass_count + 1;
				end else begin
					$display("test %0s failed", test_name);
					fail_count <= fail_count + 1;
				end
				done <= 1'b1;
			end
		end
	end

endmodule

// ==== dv/ball_golden.txt ====
# name buttons(hex) team1_pos team2_pos ticks exp_x exp_y score1_pulses score2_pulses
# serve is (463,275) heading southwest, the ball enters the (300,450) blue goal on tick 164
free_short 0 0 0 5 458 280 0 0
free_mid 0 100 400 100 363 375 0 0
free_players_near 0 300 275 120 343 395 0 0
free_goal_edge 0 50 50 163 300 438 0 0
goal_blue 0 0 0 166 461 277 0 1
goal_blue_late 0 200 300 200 427 311 0 1
goal_blue_twice 0 0 0 330 461 277 0 2
button_hold f 0 0 50 463 275 0 0
button_hold_long f 250 250 200 463 275 0 0
free_after_hold 0 0 0 10 453 285 0 0

// ==== dv/tb_ball_controller.sv ====
`timescale 1ns/1ps

module tb_ball_controller import ball_pkg::*; ();

	localparam int BALL_RADIUS = 8;
	localparam int PLAYER_RADIUS = 20;
	localparam int GOAL_RADIUS = 20;
	localparam int MOVE_PERIOD = 4;

	// phase of the cycle count at which the serve lands on a tick edge
	localparam int SERVE_PHASE = MOVE_PERIOD - 2;
	localparam int ALIGN_LIMIT = 2 * MOVE_PERIOD;
	localparam int DONE_LIMIT = 10;
	localparam int NAME_W = 8 * 24;

	logic              clk = 1'b0;
	logic              rst;
	coord_t            team1_pos;
	coord_t            team2_pos;
	logic [3:0]        buttons;
	ball_pos_t         ball_pos;
	logic              score_team1;
	logic              score_team2;

	logic              start;
	logic              strobe;
	logic [NAME_W-1:0] test_name;
	ball_pos_t         exp_pos;
	logic [7:0]        exp_s1;
	logic [7:0]        exp_s2;
	logic              done;
	int                pass_count;
	int                fail_count;
	int                cyc;
	logic              aborted;

	always #50 clk = ~clk;

	// clock edges since reset fell
	always @(posedge clk) begin
		if (rst) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	ball_controller #(
		.BALL_RADIUS  (BALL_RADIUS),
		.PLAYER_RADIUS(PLAYER_RADIUS),
		.GOAL_RADIUS  (GOAL_RADIUS),
		.MOVE_PERIOD  (MOVE_PERIOD)
	) ball_controller_inst (
		.clk        (clk),
		.rst        (rst),
		.team1_pos  (team1_pos),
		.team2_pos  (team2_pos),
		.buttons    (buttons),
		.ball_pos   (ball_pos),
		.score_team1(score_team1),
		.score_team2(score_team2)
	);

	ball_checker #(
		.NAME_W(NAME_W)
	) checker_inst (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.strobe     (strobe),
		.test_name  (test_name),
		.exp_pos    (exp_pos),
		.exp_s1     (exp_s1),
		.exp_s2     (exp_s2),
		.ball_pos   (ball_pos),
		.score_team1(score_team1),
		.score_team2(score_team2),
		.done       (done),
		.pass_count (pass_count),
		.fail_count (fail_count)
	);

	task automatic run_test(input logic [NAME_W-1:0] name, input logic [3:0] btn,
		input int t1, input int t2, input int ticks, input int ex, input int ey,
		input int s1, input int s2);
		int guard;
		guard = 0;
		@(negedge clk);
		while ((cyc % MOVE_PERIOD) != SERVE_PHASE && guard < ALIGN_LIMIT) begin
			@(negedge clk);
			guard++;
		end
		if ((cyc % MOVE_PERIOD) != SERVE_PHASE) begin
			$display("timeout while aligning test %0s to the move tick", name);
			aborted = 1'b1;
		end else begin
			test_name = name;
			exp_pos.x = coord_t'(ex);
			exp_pos.y = coord_t'(ey);
			exp_s1 = 8'(s1);
			exp_s2 = 8'(s2);
			team1_pos = coord_t'(t1);
			team2_pos = coord_t'(t2);
			// one cycle of all buttons puts the ball on the serve point
			buttons = 4'hf;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
			buttons = btn;
			repeat (ticks * MOVE_PERIOD + 1) @(negedge clk);
			strobe = 1'b1;
			guard = 0;
			do begin
				@(negedge clk);
				guard++;
			end while (!done && guard < DONE_LIMIT);
			strobe = 1'b0;
			if (!done) begin
				$display("timeout waiting for the checker on test %0s", name);
				aborted = 1'b1;
			end
		end
	endtask

	initial begin
		int                fd;
		int                code;
		string             line;
		logic [NAME_W-1:0] name;
		logic [3:0]        btn;
		int                t1;
		int                t2;
		int                ticks;
		int                ex;
		int                ey;
		int                s1;
		int                s2;

		rst = 1'b1;
		team1_pos = '0;
		team2_pos = '0;
		buttons = '0;
		start = 1'b0;
		strobe = 1'b0;
		test_name = '0;
		exp_pos = '0;
		exp_s1 = '0;
		exp_s2 = '0;
		aborted = 1'b0;

		repeat (10) @(negedge clk);
		rst = 1'b0;

		fd = $fopen("dv/ball_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/ball_golden.txt");
			aborted = 1'b1;
		end
		while (fd != 0 && !aborted && !$feof(fd)) begin
			code = $fgets(line, fd);
			// 8'h23 is the comment character
			if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
				code = $sscanf(line, "%s %h %d %d %d %d %d %d %d",
					name, btn, t1, t2, ticks, ex, ey, s1, s2);
				if (code != 9) begin
					$display("malformed line in dv/ball_golden.txt: %s", line);
					aborted = 1'b1;
				end else begin
					run_test(name, btn, t1, t2, ticks, ex, ey, s1, s2);
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		repeat (2) @(negedge clk);
		$display("%0d passed, %0d failed", pass_count, fail_count);
		if (aborted || fail_count != 0 || pass_count == 0) begin
			$display("tests failed");
		end else begin
			$display("all tests passed");
		end
		$finish;
	end

endmodule

// ==== hdl/ball_controller.sv ====
`timescale 1ns/1ps

module ball_controller import ball_pkg::*; #(
	parameter int BALL_RADIUS = 8,
	parameter int PLAYER_RADIUS = 20,
	parameter int GOAL_RADIUS = 20,
	parameter int MOVE_PERIOD = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  coord_t     team1_pos,
	input  coord_t     team2_pos,
	input  logic [3:0] buttons,
	output ball_pos_t  ball_pos,
	output logic       score_team1,
	output logic       score_team2
);

	logic    tick;
	logic    serve;
	bounce_t bounce;
	dir_t    dir;

	move_tick #(
		.MOVE_PERIOD(MOVE_PERIOD)
	) move_tick_inst (
		.clk (clk),
		.rst (rst),
		.tick(tick)
	);

	ball_motion #(
		.BALL_RADIUS(BALL_RADIUS)
	) ball_motion_inst (
		.clk   (clk),
		.rst   (rst),
		.tick  (tick),
		.serve (serve),
		.bounce(bounce),
		.pos   (ball_pos),
		.dir   (dir)
	);

	player_contact #(
		.BALL_RADIUS  (BALL_RADIUS),
		.PLAYER_RADIUS(PLAYER_RADIUS)
	) player_contact_inst (
		.clk      (clk),
		.rst      (rst),
		.tick     (tick),
		.pos      (ball_pos),
		.dir      (dir),
		.team1_pos(team1_pos),
		.team2_pos(team2_pos),
		.bounce   (bounce)
	);

	serve_control #(
		.BALL_RADIUS(BALL_RADIUS),
		.GOAL_RADIUS(GOAL_RADIUS)
	) serve_control_inst (
		.clk        (clk),
		.rst        (rst),
		.pos        (ball_pos),
		.buttons    (buttons),
		.serve      (serve),
		.score_team1(score_team1),
		.score_team2(score_team2)
	);

endmodule

// ==== hdl/ball_motion.sv ====
`timescale 1ns/1ps

module ball_motion import ball_pkg::*; #(
	parameter int BALL_RADIUS = 8
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      tick,
	input  logic      serve,
	input  bounce_t   bounce,
	output ball_pos_t pos,
	output dir_t      dir
);

	// ball centre limits, the edge touches the wall here
	localparam coord_t BOUND_LEFT = coord_t'(FIELD_LEFT + BALL_RADIUS);
	localparam coord_t BOUND_RIGHT = coord_t'(FIELD_RIGHT - BALL_RADIUS);
	localparam coord_t BOUND_TOP = coord_t'(FIELD_TOP + BALL_RADIUS);
	localparam coord_t BOUND_BOTTOM = coord_t'(FIELD_BOTTOM - BALL_RADIUS);

	dir_t      dir_wall;
	dir_t      dir_next;
	ball_pos_t pos_next;

	always_comb begin
		dir_wall = dir;
		// only reflect when still heading into the wall
		if ((pos.y >= BOUND_BOTTOM && goes_south(dir)) ||
			(pos.y <= BOUND_TOP && goes_north(dir))) begin
			dir_wall = mirror_y(dir_wall);
		end
		if ((pos.x <= BOUND_LEFT && goes_west(dir)) ||
			(pos.x >= BOUND_RIGHT && goes_east(dir))) begin
			dir_wall = mirror_x(dir_wall);
		end

		// player hits go on top of the wall result
		dir_next = dir_wall;
		if (bounce.flip_x) begin
			dir_next = mirror_x(dir_next);
		end
		if (bounce.flip_y) begin
			dir_next = mirror_y(dir_next);
		end

		pos_next = pos;
		if (goes_east(dir_next)) begin
			pos_next.x = pos.x + 1'b1;
		end else if (goes_west(dir_next)) begin
			pos_next.x = pos.x - 1'b1;
		end
		if (goes_south(dir_next)) begin
			pos_next.y = pos.y + 1'b1;
		end else if (goes_north(dir_next)) begin
			pos_next.y = pos.y - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || serve) begin
			pos.x <= SERVE_X;
			pos.y <= SERVE_Y;
			dir <= SERVE_DIR;
		end else if (tick) begin
			pos <= pos_next;
			dir <= dir_next;
		end
	end

	function automatic logic within_one(coord_t a, coord_t b);
		return (a == b) || (a == b + 1'b1) || (b == a + 1'b1);
	endfunction

	// only a serve may jump the ball
	assert property (@(posedge clk) disable iff (rst)
		!serve |=> within_one(pos.x, $past(pos.x)) && within_one(pos.y, $past(pos.y)))
		else $error("ball moved more than one pixel without a serve");

endmodule

// ==== hdl/ball_pkg.sv ====
package ball_pkg;

	localparam int COORD_W = 10;
	localparam int DIST_W = 22;

	typedef logic [COORD_W-1:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} ball_pos_t;

	// east is increasing x, north is decreasing y
	typedef enum logic [2:0] {
		north, northeast, east, southeast,
		south, southwest, west, northwest
	} dir_t;

	typedef struct packed {
		logic flip_x;
		logic flip_y;
	} bounce_t;

	// pitch geometry in pixels
	localparam coord_t FIELD_LEFT = 10'd150;
	localparam coord_t FIELD_RIGHT = 10'd661;
	localparam coord_t FIELD_TOP = 10'd36;
	localparam coord_t FIELD_BOTTOM = 10'd510;

	localparam coord_t SERVE_X = 10'd463;
	localparam coord_t SERVE_Y = 10'd275;
	localparam dir_t SERVE_DIR = southwest;

	// player columns, their rows come from the buttons side
	localparam coord_t PLAYER1_X = 10'd240;
	localparam coord_t PLAYER2_X = 10'd560;

	localparam coord_t GOAL_ROW_BLUE = 10'd450;
	localparam coord_t GOAL_ROW_RED = 10'd100;
	localparam coord_t GOAL_COL0 = 10'd300;
	localparam coord_t GOAL_COL1 = 10'd400;
	localparam coord_t GOAL_COL2 = 10'd500;

	function automatic logic goes_east(dir_t d);
		return d inside {northeast, east, southeast};
	endfunction

	function automatic logic goes_west(dir_t d);
		return d inside {northwest, west, southwest};
	endfunction

	function automatic logic goes_north(dir_t d);
		return d inside {northwest, north, northeast};
	endfunction

	function automatic logic goes_south(dir_t d);
		return d inside {southwest, south, southeast};
	endfunction

	// swap the horizontal component
	function automatic dir_t mirror_x(dir_t d);
		case (d)
			northeast: return northwest;
			east: return west;
			southeast: return southwest;
			northwest: return northeast;
			west: return east;
			southwest: return southeast;
			default: return d;
		endcase
	endfunction

	// swap the vertical component
	function automatic dir_t mirror_y(dir_t d);
		case (d)
			north: return south;
			northeast: return southeast;
			northwest: return southwest;
			south: return north;
			southeast: return northeast;
			southwest: return northwest;
			default: return d;
		endcase
	endfunction

	// squared distance from the ball to a circle centre
	function automatic logic [DIST_W-1:0] sq_dist(ball_pos_t p, coord_t cx, coord_t cy);
		logic [DIST_W-1:0] dx;
		logic [DIST_W-1:0] dy;
		dx = (p.x > cx) ? DIST_W'(p.x - cx) : DIST_W'(cx - p.x);
		dy = (p.y > cy) ? DIST_W'(p.y - cy) : DIST_W'(cy - p.y);
		return dx * dx + dy * dy;
	endfunction

endpackage

// ==== hdl/move_tick.sv ====
`timescale 1ns/1ps

module move_tick #(
	parameter int MOVE_PERIOD = 4
) (
	input  logic clk,
	input  logic rst,
	output logic tick
);

	localparam int CNT_W = (MOVE_PERIOD > 1) ? $clog2(MOVE_PERIOD) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MOVE_PERIOD - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign tick = (cnt == CNT_LAST);

	// a divided rate never gives back-to-back ticks
	assert property (@(posedge clk) disable iff (rst)
		(MOVE_PERIOD > 1) && tick |=> !tick)
		else $error("move tick high on two cycles in a row");

endmodule

// ==== hdl/player_contact.sv ====
`timescale 1ns/1ps

module player_contact import ball_pkg::*; #(
	parameter int BALL_RADIUS = 8,
	parameter int PLAYER_RADIUS = 20
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      tick,
	input  ball_pos_t pos,
	input  dir_t      dir,
	input  coord_t    team1_pos,
	input  coord_t    team2_pos,
	output bounce_t   bounce
);

	localparam logic [DIST_W-1:0] TOUCH_LIM = DIST_W'((BALL_RADIUS + PLAYER_RADIUS + 1) ** 2);

	logic [DIST_W-1:0] dist1;
	logic [DIST_W-1:0] dist2;
	logic              touch;
	logic              horiz;
	logic              fire;
	logic              hit_latch;

	assign dist1 = sq_dist(pos, PLAYER1_X, team1_pos);
	assign dist2 = sq_dist(pos, PLAYER2_X, team2_pos);
	assign touch = (dist1 < TOUCH_LIM) || (dist2 < TOUCH_LIM);

	// one reflection per contact episode
	assign fire = touch && !hit_latch;
	assign horiz = goes_east(dir) || goes_west(dir);

	// straight north/south hits turn around vertically
	assign bounce.flip_x = fire && horiz;
	assign bounce.flip_y = fire && !horiz;

	// held while the ball overlaps, dropped on the first clear tick
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_latch <= 1'b0;
		end else if (tick) begin
			hit_latch <= touch;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		tick |-> !(bounce.flip_x && bounce.flip_y))
		else $error("player contact asked for both flips");

endmodule

// ==== hdl/serve_control.sv ====
`timescale 1ns/1ps

module serve_control import ball_pkg::*; #(
	parameter int BALL_RADIUS = 8,
	parameter int GOAL_RADIUS = 20
) (
	input  logic       clk,
	input  logic       rst,
	input  ball_pos_t  pos,
	input  logic [3:0] buttons,
	output logic       serve,
	output logic       score_team1,
	output logic       score_team2
);

	// ball fully inside the goal circle
	localparam logic [DIST_W-1:0] GOAL_LIM = DIST_W'((GOAL_RADIUS - BALL_RADIUS) ** 2);

	logic in_blue;
	logic in_red;
	logic goal_hit;
	logic serve_req;

	assign in_blue = (sq_dist(pos, GOAL_COL0, GOAL_ROW_BLUE) < GOAL_LIM) ||
		(sq_dist(pos, GOAL_COL1, GOAL_ROW_BLUE) < GOAL_LIM) ||
		(sq_dist(pos, GOAL_COL2, GOAL_ROW_BLUE) < GOAL_LIM);

	assign in_red = (sq_dist(pos, GOAL_COL0, GOAL_ROW_RED) < GOAL_LIM) ||
		(sq_dist(pos, GOAL_COL1, GOAL_ROW_RED) < GOAL_LIM) ||
		(sq_dist(pos, GOAL_COL2, GOAL_ROW_RED) < GOAL_LIM);

	// ball is still in the goal while serve is out, count it once
	assign goal_hit = (in_blue || in_red) && !serve;

	// all four up/down buttons together
	assign serve_req = &buttons;

	always_ff @(posedge clk) begin
		if (rst) begin
			serve <= 1'b0;
			score_team1 <= 1'b0;
			score_team2 <= 1'b0;
		end else begin
			serve <= serve_req || goal_hit;
			score_team1 <= in_red && !serve;
			score_team2 <= in_blue && !serve;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		!(score_team1 && score_team2))
		else $error("both teams scored in the same cycle");

endmodule

// ==== project.f ====
hdl/ball_pkg.sv
hdl/move_tick.sv
hdl/ball_motion.sv
hdl/player_contact.sv
hdl/serve_control.sv
hdl/ball_controller.sv
dv/ball_checker.sv
dv/tb_ball_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run from the project root, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
( verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_ball_controller -f project.f -o sim_ball \
	&& ./obj_dir/sim_ball ) > sim.log 2>&1 \
	|| echo "tests failed" >> sim.log
grep -q "tests failed" sim.log \
	&& { echo "simulation FAILED, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
